//--- source/data_mem.sv
module data_mem
    import rv_exec_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic     clk,
    input  mem_req_t mem_req,
    output word_t    rdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // Upper address bits are ignored so addresses wrap
    assign idx = mem_req.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (mem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.be[b]) begin
                    mem[idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read every cycle
    always_ff @(posedge clk) begin
        rdata <= mem[idx];
    end

endmodule

//--- source/ex_stage.sv
module ex_stage
    import rv_exec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  exec_op_t issue,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output mem_req_t mem_req,
    output ex_mem_t  ex_mem
);

    word_t      op_b;
    word_t      alu_out;
    word_t      addr_sum;
    logic [4:0] shamt;
    logic [1:0] byte_off;
    logic [3:0] be_base;

    assign rs1 = issue.rs1;
    assign rs2 = issue.rs2;

    assign op_b     = issue.is_op ? rs2_data : issue.imm;
    assign shamt    = op_b[4:0];
    assign addr_sum = rs1_data + issue.imm; // Loads, stores, jalr

    always_comb begin
        case (issue.funct3)
            3'b000: begin
                if (issue.is_op && issue.funct7_alt) begin
                    alu_out = rs1_data - op_b;
                end else begin
                    alu_out = rs1_data + op_b;
                end
            end
            3'b001: alu_out = rs1_data << shamt;
            3'b010: alu_out = word_t'($signed(rs1_data) < $signed(op_b));
            3'b011: alu_out = word_t'(rs1_data < op_b);
            3'b100: alu_out = rs1_data ^ op_b;
            3'b101: begin
                if (issue.funct7_alt) begin
                    alu_out = word_t'($signed(rs1_data) >>> shamt);
                end else begin
                    alu_out = rs1_data >> shamt;
                end
            end
            3'b110: alu_out = rs1_data | op_b;
            default: alu_out = rs1_data & op_b;
        endcase
    end

    // Store lanes shifted past byte 3 fall off
    assign byte_off = addr_sum[1:0];

    always_comb begin
        case (issue.funct3[1:0])
            2'b00:   be_base = 4'b0001;
            2'b01:   be_base = 4'b0011;
            default: be_base = 4'b1111;
        endcase
    end

    assign mem_req.we    = issue.valid & issue.is_store;
    assign mem_req.addr  = addr_sum;
    assign mem_req.wdata = rs2_data << {byte_off, 3'b000};
    assign mem_req.be    = be_base << byte_off;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= issue.valid;
            ex_mem.rd         <= issue.rd;
            ex_mem.rd_we      <= issue.valid & ~issue.is_store & (issue.rd != '0);
            ex_mem.rd_is_mem  <= issue.is_load;
            ex_mem.is_lui     <= issue.is_lui;
            ex_mem.is_auipc   <= issue.is_auipc;
            ex_mem.is_jal     <= issue.is_jal;
            ex_mem.is_jalr    <= issue.is_jalr;
            ex_mem.funct3     <= issue.funct3;
            ex_mem.alu_result <= (issue.is_op | issue.is_op_imm) ? alu_out : addr_sum;
            ex_mem.imm        <= issue.imm;
            ex_mem.snpc       <= issue.pc + 32'd4;
            ex_mem.pc_imm     <= issue.pc + issue.imm;
            ex_mem.pc         <= issue.pc;
        end
    end

endmodule

//--- source/exec_core.sv
module exec_core
    import rv_exec_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic     clk,
    input  logic     arst_n,
    input  exec_op_t issue,
    output retire_t  retire
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    mem_req_t mem_req;
    ex_mem_t  ex_mem;
    word_t    rdata;
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_value;

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_value(wb_value)
    );

    ex_stage u_ex_stage (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .mem_req (mem_req),
        .ex_mem  (ex_mem)
    );

    data_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) u_data_mem (
        .clk    (clk),
        .mem_req(mem_req),
        .rdata  (rdata)
    );

    wb_stage u_wb_stage (
        .clk     (clk),
        .arst_n  (arst_n),
        .ex_mem  (ex_mem),
        .rdata   (rdata),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_value(wb_value),
        .retire  (retire)
    );

endmodule

//--- source/key_mux.sv
module key_mux #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
    input  logic [KEY_LEN-1:0]                   key,
    input  logic [DATA_LEN-1:0]                  default_out,
    output logic [DATA_LEN-1:0]                  out
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    logic [PAIR_LEN-1:0] pair;

    // Pairs sit key-first with the first listed pair in the top bits
    always_comb begin
        out  = default_out;
        pair = '0;
        // Walk upwards so the first listed match is the last to land
        for (int i = 0; i < NR_KEY; i++) begin
            pair = lut[i*PAIR_LEN +: PAIR_LEN];
            if (pair[PAIR_LEN-1 -: KEY_LEN] == key) begin
                out = pair[DATA_LEN-1:0];
            end
        end
    end

endmodule

//--- source/reg_file.sv
module reg_file
    import rv_exec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    input  word_t    wb_value
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // Read with write-back bypass
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (wb_we && wb_rd == rs1) begin
            rs1_data = wb_value;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (wb_we && wb_rd == rs2) begin
            rs2_data = wb_value;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

//--- source/rv_exec_pkg.sv
package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // Decoded op as handed over by the decoder
    typedef struct packed {
        logic     valid;
        logic     is_lui;
        logic     is_auipc;
        logic     is_jal;
        logic     is_jalr;
        logic     is_load;
        logic     is_store;
        logic     is_op;      // reg-reg
        logic     is_op_imm;
        funct3_t  funct3;
        logic     funct7_alt; // sub / sra
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        word_t    pc;
    } exec_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        logic     rd_is_mem;
        logic     is_lui;
        logic     is_auipc;
        logic     is_jal;
        logic     is_jalr;
        funct3_t  funct3;
        word_t    alu_result;
        word_t    imm;
        word_t    snpc;
        word_t    pc_imm;
        word_t    pc;
    } ex_mem_t;

    typedef struct packed {
        logic       we;
        word_t      addr;
        word_t      wdata; // Already in its byte lanes
        logic [3:0] be;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        word_t    value;
        word_t    pc;
    } retire_t;

endpackage

//--- source/wb_stage.sv
module wb_stage
    import rv_exec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  ex_mem_t  ex_mem,
    input  word_t    rdata,
    output logic     wb_we,
    output reg_idx_t wb_rd,
    output word_t    wb_value,
    output retire_t  retire
);

    word_t srd;

    wbu u_wbu (
        .ex_mem(ex_mem),
        .mem_r (rdata),
        .srd   (srd)
    );

    assign wb_we    = ex_mem.valid & ex_mem.rd_we;
    assign wb_rd    = ex_mem.rd;
    assign wb_value = srd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire.valid <= ex_mem.valid;
            retire.rd    <= ex_mem.rd;
            retire.rd_we <= wb_we;
            retire.value <= srd;
            retire.pc    <= ex_mem.pc;
        end
    end

endmodule

//--- source/wbu.sv
module wbu
    import rv_exec_pkg::*;
(
    input  ex_mem_t ex_mem,
    input  word_t   mem_r,
    output word_t   srd
);

    word_t mem_r_shift;
    word_t mem_r_extend;

    // Byte offset comes from the low address bits
    key_mux #(
        .NR_KEY  (4),
        .KEY_LEN (2),
        .DATA_LEN($bits(word_t))
    ) u_shift_mux (
        .lut        ({
            2'b00, mem_r,
            2'b01, {8'b0, mem_r[31:8]},
            2'b10, {16'b0, mem_r[31:16]},
            2'b11, {24'b0, mem_r[31:24]}
        }),
        .key        (ex_mem.alu_result[1:0]),
        .default_out(mem_r),
        .out        (mem_r_shift)
    );

    key_mux #(
        .NR_KEY  (5),
        .KEY_LEN ($bits(funct3_t)),
        .DATA_LEN($bits(word_t))
    ) u_extend_mux (
        .lut        ({
            3'b000, {{24{mem_r_shift[7]}}, mem_r_shift[7:0]},   // lb
            3'b001, {{16{mem_r_shift[15]}}, mem_r_shift[15:0]}, // lh
            3'b010, mem_r_shift,
            3'b100, {24'b0, mem_r_shift[7:0]},
            3'b101, {16'b0, mem_r_shift[15:0]}
        }),
        .key        (ex_mem.funct3),
        .default_out(word_t'(0)),
        .out        (mem_r_extend)
    );

    always_comb begin
        if (ex_mem.is_lui) begin
            srd = ex_mem.imm;
        end else if (ex_mem.is_auipc) begin
            srd = ex_mem.pc_imm;
        end else if (ex_mem.is_jal || ex_mem.is_jalr) begin
            srd = ex_mem.snpc; // Link value only
        end else if (ex_mem.rd_is_mem) begin
            srd = mem_r_extend;
        end else begin
            srd = ex_mem.alu_result;
        end
    end

endmodule

//--- sources.f
source/rv_exec_pkg.sv
source/key_mux.sv
source/reg_file.sv
source/ex_stage.sv
source/data_mem.sv
source/wbu.sv
source/wb_stage.sv
source/exec_core.sv
verif/exec_core_chk.sv
verif/exec_core_tb.sv

//--- verif/exec_core_chk.sv
module exec_core_chk
    import rv_exec_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    issue_valid,
    input retire_t retire
);

    int fail_count;

    initial fail_count = 0;

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        retire.valid == $past(issue_valid, 2))
        else begin
            fail_count++;
            $error("retire.valid does not follow issue.valid by two edges");
        end

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !retire.valid)
        else begin
            fail_count++;
            $error("retire.valid high while reset is asserted");
        end

    // x0 is never a real write target
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(retire.rd_we && retire.rd == '0))
        else begin
            fail_count++;
            $error("retire carries rd_we with rd equal to zero");
        end

endmodule

bind exec_core exec_core_chk u_exec_core_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .issue_valid(issue.valid),
    .retire     (retire)
);

//--- verif/exec_core_tb.sv
module exec_core_tb;
    import rv_exec_pkg::*;

    localparam int MEM_WORDS = 64;
    localparam int PERIOD    = 20;
    localparam int N_RAND    = 2000;
    localparam int N_OPS     = MEM_WORDS + N_RAND;

    logic     clk;
    logic     arst_n;
    exec_op_t issue;
    retire_t  retire;

    integer   seed;
    int       edge_cnt;
    int       mismatches;
    int       other_errors;
    reg_idx_t last_rd;
    word_t    model_regs [32];
    word_t    model_mem [MEM_WORDS];
    retire_t  exp_q [$];
    int       exp_edge_q [$];

    exec_core #(.MEM_WORDS(MEM_WORDS)) u_exec_core (
        .clk   (clk),
        .arst_n(arst_n),
        .issue (issue),
        .retire(retire)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic word_t alu_model(input exec_op_t op, input word_t a, input word_t b);
        int sh;
        sh = b[4:0];
        case (op.funct3)
            3'd0: return (op.is_op && op.funct7_alt) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return op.funct7_alt ? word_t'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Shift down by byte offset then extend
    function automatic word_t load_model(input funct3_t f3, input word_t w, input int off);
        word_t s;
        s = w >> (8 * off);
        case (f3)
            3'd0: return {{24{s[7]}}, s[7:0]};
            3'd1: return {{16{s[15]}}, s[15:0]};
            3'd2: return s;
            3'd4: return {24'b0, s[7:0]};
            3'd5: return {16'b0, s[15:0]};
            default: return '0;
        endcase
    endfunction

    task automatic model_issue(input exec_op_t op);
        word_t   a;
        word_t   b;
        word_t   addr;
        int      idx;
        int      nbytes;
        retire_t r;
        a = (op.rs1 == '0) ? '0 : model_regs[op.rs1];
        b = (op.rs2 == '0) ? '0 : model_regs[op.rs2];
        addr = a + op.imm;
        idx = (addr >> 2) % MEM_WORDS; // Wraps
        r = '0;
        if (op.is_lui) r.value = op.imm;
        else if (op.is_auipc) r.value = op.pc + op.imm;
        else if (op.is_jal || op.is_jalr) r.value = op.pc + 32'd4;
        else if (op.is_load) r.value = load_model(op.funct3, model_mem[idx], addr[1:0]);
        else if (op.is_op) r.value = alu_model(op, a, b);
        else if (op.is_op_imm) r.value = alu_model(op, a, op.imm);
        else r.value = addr;
        if (op.is_store) begin
            nbytes = (op.funct3[1:0] == 2'd0) ? 1 : (op.funct3[1:0] == 2'd1) ? 2 : 4;
            for (int k = 0; k < nbytes; k++) begin
                if (addr[1:0] + k < 4) model_mem[idx][(addr[1:0] + k) * 8 +: 8] = b[k * 8 +: 8];
            end
        end
        r.valid = 1'b1;
        r.rd    = op.rd;
        r.rd_we = !op.is_store && op.rd != '0;
        r.pc    = op.pc;
        if (r.rd_we) model_regs[op.rd] = r.value;
        exp_q.push_back(r);
        exp_edge_q.push_back(edge_cnt + 2);
    endtask

    task automatic random_op(output exec_op_t op);
        int    kind;
        word_t rnd;
        op = '0;
        op.valid      = ($random(seed) & 3) != 0;
        kind          = {$random(seed)} % 8;
        op.funct3     = $random(seed);
        op.funct7_alt = $random(seed);
        op.rs1        = $random(seed);
        op.rs2        = $random(seed);
        op.rd         = $random(seed);
        op.pc         = $random(seed) & 32'hffff_fffc;
        if (($random(seed) & 3) == 0) op.rs1 = last_rd; // Dependent on previous op
        rnd    = $random(seed);
        op.imm = {{20{rnd[11]}}, rnd[11:0]};
        case (kind)
            0: begin
                op.is_op = 1'b1;
                op.imm   = rnd;
            end
            1: op.is_op_imm = 1'b1;
            2: begin
                op.is_lui = 1'b1;
                op.imm    = {rnd[31:12], 12'b0};
            end
            3: begin
                op.is_auipc = 1'b1;
                op.imm      = {rnd[31:12], 12'b0};
            end
            4: begin
                op.is_jal = 1'b1;
                op.imm    = {{11{rnd[20]}}, rnd[20:1], 1'b0};
            end
            5: op.is_jalr = 1'b1;
            6: op.is_load = 1'b1;
            default: begin
                op.is_store = 1'b1;
                op.funct3   = {$random(seed)} % 3;
            end
        endcase
    endtask

    task automatic drive_op(input exec_op_t op);
        @(posedge clk);
        #2;
        issue = op;
        if (op.valid) begin
            model_issue(op);
            last_rd = op.rd;
        end
    endtask

    always @(negedge clk) begin : retire_monitor
        retire_t exp_r;
        int      exp_edge;
        if (arst_n && retire.valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Retire at pc %h arrived with no op outstanding", retire.pc);
            end else begin
                exp_r    = exp_q.pop_front();
                exp_edge = exp_edge_q.pop_front();
                if (exp_edge != edge_cnt) begin
                    other_errors++;
                    $display("Retire at pc %h came at edge %0d instead of edge %0d",
                             retire.pc, edge_cnt, exp_edge);
                end
                check_word("retire.value", retire.value, exp_r.value);
                check_idx("retire.rd", retire.rd, exp_r.rd);
                check_flag("retire.rd_we", retire.rd_we, exp_r.rd_we);
                check_word("retire.pc", retire.pc, exp_r.pc);
            end
        end
    end

    initial begin
        #(PERIOD * (N_OPS + 100));
        $display("Watchdog expired with %0d retires still outstanding", exp_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        exec_op_t op;
        int       asrt_fails;
        clk          = 1'b0;
        arst_n       = 1'b0;
        issue        = '0;
        seed         = 32'h1377_8587;
        edge_cnt     = 0;
        mismatches   = 0;
        other_errors = 0;
        last_rd      = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        // sw of x0 into every word so no load sees X
        for (int i = 0; i < MEM_WORDS; i++) begin
            op          = '0;
            op.valid    = 1'b1;
            op.is_store = 1'b1;
            op.funct3   = 3'b010;
            op.rd       = $random(seed);
            op.imm      = i * 4;
            op.pc       = i * 4;
            drive_op(op);
        end
        for (int i = 0; i < N_RAND; i++) begin
            random_op(op);
            drive_op(op);
        end
        drive_op('0);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        asrt_fails = u_exec_core.u_exec_core_chk.fail_count;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, other_errors, asrt_fails);
        if (mismatches == 0 && other_errors == 0 && asrt_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
